//--- project.f
+incdir+include
rtl/cfg_chain_pkg.sv
rtl/cfg_frame_sender.sv
rtl/config_node.sv
rtl/cfg_chain_top.sv
bench/cfg_chain_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the configuration chain testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module cfg_chain_tb \
  -Mdir obj_dir \
  -o cfg_chain_sim

./obj_dir/cfg_chain_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- bench/cfg_chain_tb.sv
`default_nettype none

`include "cfg_chain_config.svh"

module cfg_chain_tb;

  localparam int frame_cycles_lp = 2 * `CFG_FRAME_WIDTH;  // Frame bits plus idle gap
  localparam int busy_limit_lp   = 4 * `CFG_FRAME_WIDTH;
  localparam int check_limit_lp  = 8 * `CFG_FRAME_WIDTH;
  localparam int random_frames_lp = 200;

  logic                      clk;
  logic                      reset;
  logic                      send;
  cfg_chain_pkg::cfg_id_t    send_id;
  cfg_chain_pkg::cfg_len_t   send_len;
  cfg_chain_pkg::cfg_data_t  send_data;
  logic                      busy;
  logic [`CFG_NODE0_BITS-1:0] config0;
  logic [`CFG_NODE1_BITS-1:0] config1;
  logic [`CFG_NODE2_BITS-1:0] config2;
  cfg_chain_pkg::cfg_count_t count0;
  cfg_chain_pkg::cfg_count_t count1;
  cfg_chain_pkg::cfg_count_t count2;

  cfg_chain_pkg::cfg_data_t  model_config [3];  // Expected register per node
  cfg_chain_pkg::cfg_count_t model_count [3];   // Expected update count per node
  logic [31:0]               lfsr_state;
  int                        checks;
  int                        errors;
  bit                        timed_out;
  bit                        check_req;         // Set by stimulus, cleared by the compare process

  cfg_chain_top cfg_chain_top_inst (
    .clk_i       (clk),
    .reset       (reset),
    .send_i      (send),
    .send_id_i   (send_id),
    .send_len_i  (send_len),
    .send_data_i (send_data),
    .busy_o      (busy),
    .config0_o   (config0),
    .config1_o   (config1),
    .config2_o   (config2),
    .count0_o    (count0),
    .count1_o    (count1),
    .count2_o    (count2)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    logic        fb;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic cfg_chain_pkg::cfg_id_t node_id(input int n);
    case (n)
      0:       return cfg_chain_pkg::cfg_id_t'(`CFG_NODE0_ID);
      1:       return cfg_chain_pkg::cfg_id_t'(`CFG_NODE1_ID);
      default: return cfg_chain_pkg::cfg_id_t'(`CFG_NODE2_ID);
    endcase
  endfunction

  function automatic cfg_chain_pkg::cfg_len_t node_bits(input int n);
    case (n)
      0:       return cfg_chain_pkg::cfg_len_t'(`CFG_NODE0_BITS);
      1:       return cfg_chain_pkg::cfg_len_t'(`CFG_NODE1_BITS);
      default: return cfg_chain_pkg::cfg_len_t'(`CFG_NODE2_BITS);
    endcase
  endfunction

  function automatic cfg_chain_pkg::cfg_data_t node_default(input int n);
    case (n)
      0:       return cfg_chain_pkg::cfg_data_t'(`CFG_NODE0_DEFAULT);
      1:       return cfg_chain_pkg::cfg_data_t'(`CFG_NODE1_DEFAULT);
      default: return cfg_chain_pkg::cfg_data_t'(`CFG_NODE2_DEFAULT);
    endcase
  endfunction

  // Reference model of one node for one frame
  function automatic void predict_node(
    input  int                        n,
    input  cfg_chain_pkg::cfg_id_t    id,
    input  cfg_chain_pkg::cfg_len_t   len,
    input  cfg_chain_pkg::cfg_data_t  data,
    input  cfg_chain_pkg::cfg_data_t  cur_config,
    input  cfg_chain_pkg::cfg_count_t cur_count,
    output cfg_chain_pkg::cfg_data_t  new_config,
    output cfg_chain_pkg::cfg_count_t new_count
  );
    logic [31:0] mask;
    mask       = (32'd1 << node_bits(n)) - 32'd1;  // Low bits the register keeps
    new_config = cur_config;
    new_count  = cur_count;
    if (id == cfg_chain_pkg::cfg_id_t'(`CFG_RESET_ID)) begin
      new_config = node_default(n);
      new_count  = '0;
    end else if (id == node_id(n) && len == node_bits(n)) begin
      new_config = data & cfg_chain_pkg::cfg_data_t'(mask);
      new_count  = cur_count + 8'd1;  // Wraps like the hardware counter
    end
  endfunction

  task automatic check_config(input string what, input cfg_chain_pkg::cfg_data_t actual,
                              input cfg_chain_pkg::cfg_data_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(input string what, input cfg_chain_pkg::cfg_count_t actual,
                             input cfg_chain_pkg::cfg_count_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_outputs();
    check_config("config0_o", cfg_chain_pkg::cfg_data_t'(config0), model_config[0]);
    check_config("config1_o", cfg_chain_pkg::cfg_data_t'(config1), model_config[1]);
    check_config("config2_o", cfg_chain_pkg::cfg_data_t'(config2), model_config[2]);
    check_count("count0_o", count0, model_count[0]);
    check_count("count1_o", count1, model_count[1]);
    check_count("count2_o", count2, model_count[2]);
    check_flag("busy_o", busy, 1'b0);
    check_flag("cfg_bit line", cfg_chain_top_inst.cfg_bit, 1'b1);  // Back to idle
  endtask

  // Called one time unit after a rising edge with the sender idle
  task automatic send_frame(input cfg_chain_pkg::cfg_id_t id, input cfg_chain_pkg::cfg_len_t len,
                            input cfg_chain_pkg::cfg_data_t data);
    int                        n;
    int                        wait_cycles;
    cfg_chain_pkg::cfg_data_t  new_config;
    cfg_chain_pkg::cfg_count_t new_count;
    if (!timed_out) begin
      send      = 1'b1;
      send_id   = id;
      send_len  = len;
      send_data = data;
      @(posedge clk);
      #1;
      send = 1'b0;
      for (n = 0; n < 3; n++) begin
        predict_node(n, id, len, data, model_config[n], model_count[n], new_config, new_count);
        model_config[n] = new_config;
        model_count[n]  = new_count;
      end
      check_req   = 1'b1;
      wait_cycles = 0;
      while (check_req && wait_cycles < check_limit_lp) begin
        @(posedge clk);
        #1;
        wait_cycles++;
      end
      if (check_req) begin
        timed_out = 1'b1;
        $display("Timeout: frame check did not finish within %0d cycles", check_limit_lp);
      end
    end
  endtask

  // Compare process, one check per frame once busy_o has fallen
  // Outputs are sampled on the falling edge, half a cycle after they settle
  initial begin
    int busy_cycles;
    forever begin
      @(negedge clk);
      if (check_req) begin
        busy_cycles = 0;
        while (busy && busy_cycles < busy_limit_lp) begin
          busy_cycles++;
          @(negedge clk);
        end
        if (busy) begin
          timed_out = 1'b1;
          $display("Timeout: busy_o did not fall within %0d cycles", busy_limit_lp);
        end else begin
          checks++;
          if (busy_cycles != frame_cycles_lp) begin
            errors++;
            $display("error at %0t: busy_o was high for %0d cycles, expected %0d",
                     $time, busy_cycles, frame_cycles_lp);
          end
          check_outputs();
        end
        check_req = 1'b0;
      end
    end
  end

  initial begin
    int                       frame_idx;
    int                       pick;
    logic [31:0]              kind;
    cfg_chain_pkg::cfg_id_t   id;
    cfg_chain_pkg::cfg_len_t  len;
    cfg_chain_pkg::cfg_data_t data;
    reset      = 1'b1;
    send       = 1'b0;
    send_id    = '0;
    send_len   = '0;
    send_data  = '0;
    lfsr_state = 32'hb5ea;
    checks     = 0;
    errors     = 0;
    timed_out  = 1'b0;
    check_req  = 1'b0;
    for (pick = 0; pick < 3; pick++) begin
      model_config[pick] = node_default(pick);
      model_count[pick]  = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    check_outputs();  // Defaults and zero counts after reset

    send_frame(node_id(0), node_bits(0), 16'hbe3c);
    send_frame(node_id(1), node_bits(1), 16'h0f0f);
    send_frame(node_id(2), node_bits(2), 16'h0006);
    send_frame(node_id(0), node_bits(0), 16'h0000);  // Zero data must not restart a frame
    send_frame(node_id(1), node_bits(0), 16'hffff);  // Wrong length
    send_frame(node_id(2), node_bits(1), 16'h0003);
    send_frame(4'h7, node_bits(0), 16'h00ff);        // ID no node has
    send_frame(4'h0, node_bits(2), 16'h0000);
    send_frame(cfg_chain_pkg::cfg_id_t'(`CFG_RESET_ID), '0, 16'h0000);

    for (frame_idx = 0; frame_idx < random_frames_lp && !timed_out; frame_idx++) begin
      kind = random_bits(3);
      if (kind < 5) begin
        pick = int'(random_bits(2)) % 3;
        id   = node_id(pick);
        len  = random_bits(1) ? node_bits(pick) : cfg_chain_pkg::cfg_len_t'(random_bits(5));
      end else if (kind < 7) begin
        id  = cfg_chain_pkg::cfg_id_t'(random_bits(4));
        len = cfg_chain_pkg::cfg_len_t'(random_bits(5));
      end else begin
        id  = cfg_chain_pkg::cfg_id_t'(`CFG_RESET_ID);
        len = cfg_chain_pkg::cfg_len_t'(random_bits(5));
      end
      data = cfg_chain_pkg::cfg_data_t'(random_bits(16));
      send_frame(id, len, data);
    end

    $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
    if (timed_out || errors != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/cfg_chain_top.sv
`default_nettype none

`include "cfg_chain_config.svh"

module cfg_chain_top (
  input  wire                          clk_i,
  input  wire                          reset,
  input  wire                          send_i,
  input  wire cfg_chain_pkg::cfg_id_t      send_id_i,
  input  wire cfg_chain_pkg::cfg_len_t     send_len_i,
  input  wire cfg_chain_pkg::cfg_data_t    send_data_i,
  output logic                         busy_o,
  output logic [`CFG_NODE0_BITS-1:0]   config0_o,
  output logic [`CFG_NODE1_BITS-1:0]   config1_o,
  output logic [`CFG_NODE2_BITS-1:0]   config2_o,
  output cfg_chain_pkg::cfg_count_t    count0_o,
  output cfg_chain_pkg::cfg_count_t    count1_o,
  output cfg_chain_pkg::cfg_count_t    count2_o
);

  logic cfg_bit;  // Shared serial line, high when idle

  cfg_frame_sender cfg_frame_sender_inst (
    .clk_i  (clk_i),
    .reset  (reset),
    .send_i (send_i),
    .id_i   (send_id_i),
    .len_i  (send_len_i),
    .data_i (send_data_i),
    .bit_o  (cfg_bit),
    .busy_o (busy_o)
  );

  config_node #(
    .id_p          (`CFG_NODE0_ID),
    .config_bits_p (`CFG_NODE0_BITS),
    .default_p     (`CFG_NODE0_DEFAULT)
  ) config_node0_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (config0_o),
    .count_o  (count0_o)
  );

  config_node #(
    .id_p          (`CFG_NODE1_ID),
    .config_bits_p (`CFG_NODE1_BITS),
    .default_p     (`CFG_NODE1_DEFAULT)
  ) config_node1_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (config1_o),
    .count_o  (count1_o)
  );

  config_node #(
    .id_p          (`CFG_NODE2_ID),
    .config_bits_p (`CFG_NODE2_BITS),
    .default_p     (`CFG_NODE2_DEFAULT)
  ) config_node2_inst (
    .clk_i    (clk_i),
    .reset    (reset),
    .bit_i    (cfg_bit),
    .config_o (config2_o),
    .count_o  (count2_o)
  );

endmodule

`default_nettype wire

//--- rtl/config_node.sv
`default_nettype none

`include "cfg_chain_config.svh"

module config_node #(
  parameter cfg_chain_pkg::cfg_id_t     id_p          = '0,
  parameter int                         config_bits_p = 8,
  parameter logic [config_bits_p-1:0]   default_p     = '0
) (
  input  wire                        clk_i,
  input  wire                        reset,
  input  wire                        bit_i,
  output logic [config_bits_p-1:0]   config_o,
  output cfg_chain_pkg::cfg_count_t  count_o
);

  localparam int frame_width_lp   = `CFG_FRAME_WIDTH;
  localparam int len_lsb_lp       = 1;
  localparam int id_lsb_lp        = len_lsb_lp + `CFG_LEN_WIDTH;
  localparam int data_lsb_lp      = id_lsb_lp + `CFG_ID_WIDTH;
  localparam int holdoff_width_lp = $clog2(frame_width_lp);
  localparam logic [holdoff_width_lp-1:0] holdoff_init_lp =
    holdoff_width_lp'(frame_width_lp - 1);

  logic [frame_width_lp-1:0]   shift_r;    // Last frame's worth of line bits
  logic [holdoff_width_lp-1:0] holdoff_r;  // Cycles left to ignore the line
  logic [config_bits_p-1:0]    config_r;
  cfg_chain_pkg::cfg_count_t   count_r;

  cfg_chain_pkg::cfg_len_t     frame_len_w;
  cfg_chain_pkg::cfg_id_t      frame_id_w;
  cfg_chain_pkg::cfg_data_t    frame_data_w;
  logic                        start_w;
  logic                        reset_frame_w;
  logic                        match_w;

  // Field view of the shift register once the start bit sits at bit 0
  assign frame_len_w  = shift_r[len_lsb_lp +: `CFG_LEN_WIDTH];
  assign frame_id_w   = shift_r[id_lsb_lp +: `CFG_ID_WIDTH];
  assign frame_data_w = shift_r[data_lsb_lp +: `CFG_DATA_WIDTH];

  assign start_w       = !shift_r[0] && (holdoff_r == '0);
  assign reset_frame_w = start_w && (frame_id_w == cfg_chain_pkg::cfg_id_t'(`CFG_RESET_ID));
  assign match_w       = start_w && (frame_id_w == id_p)
                       && (frame_len_w == cfg_chain_pkg::cfg_len_t'(config_bits_p));

  // New bits enter at the top and walk down to bit 0
  always_ff @(posedge clk_i) begin
    if (reset) begin
      shift_r <= '1;  // Looks like an idle line
    end else begin
      shift_r <= {bit_i, shift_r[frame_width_lp-1:1]};
    end
  end

  // Holdoff keeps zeros inside the data from reading as a start bit
  always_ff @(posedge clk_i) begin
    if (reset) begin
      holdoff_r <= '0;
    end else if (start_w) begin
      holdoff_r <= holdoff_init_lp;
    end else if (holdoff_r != '0) begin
      holdoff_r <= holdoff_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      config_r <= default_p;
      count_r  <= '0;
    end else if (reset_frame_w) begin
      config_r <= default_p;  // Broadcast reset frame
      count_r  <= '0;
    end else if (match_w) begin
      config_r <= frame_data_w[config_bits_p-1:0];
      count_r  <= count_r + 1'b1;  // Wraps
    end
  end

  assign config_o = config_r;
  assign count_o  = count_r;

  // After a start the rest of the frame is never taken as another start
  holdoff_blocks_start_a : assert property (
    @(posedge clk_i) disable iff (reset)
    start_w |=> (!start_w) [*(frame_width_lp - 1)]
  );

  // Register only moves on a decoded frame or a reset
  config_change_a : assert property (
    @(posedge clk_i) disable iff (reset)
    $changed(config_r) |-> ($past(start_w) || $past(reset))
  );

endmodule

`default_nettype wire

//--- rtl/cfg_frame_sender.sv
`default_nettype none

`include "cfg_chain_config.svh"

module cfg_frame_sender (
  input  wire                       clk_i,
  input  wire                       reset,
  input  wire                       send_i,
  input  wire cfg_chain_pkg::cfg_id_t   id_i,
  input  wire cfg_chain_pkg::cfg_len_t  len_i,
  input  wire cfg_chain_pkg::cfg_data_t data_i,
  output logic                      bit_o,
  output logic                      busy_o
);

  localparam int frame_width_lp = `CFG_FRAME_WIDTH;
  localparam int count_width_lp = $clog2(frame_width_lp);
  localparam logic [count_width_lp-1:0] last_bit_lp = count_width_lp'(frame_width_lp - 1);

  cfg_chain_pkg::sender_state_t state_r;
  logic [frame_width_lp-1:0]    frame_w;     // Frame as sent, bit 0 first
  logic [frame_width_lp-1:0]    shift_r;     // Bits still to go out
  logic [count_width_lp-1:0]    count_r;     // Bit index within SEND or GAP
  logic                         bit_r;
  logic                         accept_w;

  assign frame_w  = {data_i, id_i, len_i, 1'b0};  // Start bit is zero
  assign accept_w = send_i && (state_r == cfg_chain_pkg::IDLE);

  // State, bit counter and the registered line
  always_ff @(posedge clk_i) begin
    if (reset) begin
      state_r <= cfg_chain_pkg::IDLE;
      count_r <= '0;
      bit_r   <= 1'b1;
    end else begin
      case (state_r)
        cfg_chain_pkg::IDLE: begin
          bit_r <= 1'b1;
          if (send_i) begin
            state_r <= cfg_chain_pkg::SEND;
            count_r <= '0;
            bit_r   <= frame_w[0];  // Start bit goes out with busy
          end
        end
        cfg_chain_pkg::SEND: begin
          if (count_r == last_bit_lp) begin
            state_r <= cfg_chain_pkg::GAP;
            count_r <= '0;
            bit_r   <= 1'b1;
          end else begin
            count_r <= count_r + 1'b1;
            bit_r   <= shift_r[0];
          end
        end
        cfg_chain_pkg::GAP: begin
          bit_r <= 1'b1;  // Idle ones flush every node
          if (count_r == last_bit_lp) begin
            state_r <= cfg_chain_pkg::IDLE;
            count_r <= '0;
          end else begin
            count_r <= count_r + 1'b1;
          end
        end
        default: begin
          state_r <= cfg_chain_pkg::IDLE;
          count_r <= '0;
          bit_r   <= 1'b1;
        end
      endcase
    end
  end

  // Frame payload, shifted right with ones behind it
  always_ff @(posedge clk_i) begin
    if (accept_w) begin
      shift_r <= {1'b1, frame_w[frame_width_lp-1:1]};
    end else if (state_r == cfg_chain_pkg::SEND) begin
      shift_r <= {1'b1, shift_r[frame_width_lp-1:1]};
    end
  end

  assign bit_o  = bit_r;
  assign busy_o = (state_r != cfg_chain_pkg::IDLE);

  // The line is never low outside a frame
  idle_line_high_a : assert property (
    @(posedge clk_i) disable iff (reset)
    (state_r == cfg_chain_pkg::IDLE) |-> bit_o
  );

endmodule

`default_nettype wire

//--- rtl/cfg_chain_pkg.sv
`default_nettype none

`include "cfg_chain_config.svh"

package cfg_chain_pkg;

  typedef logic [`CFG_ID_WIDTH-1:0]    cfg_id_t;     // Node ID field
  typedef logic [`CFG_LEN_WIDTH-1:0]   cfg_len_t;    // Length field
  typedef logic [`CFG_DATA_WIDTH-1:0]  cfg_data_t;   // Full data field
  typedef logic [`CFG_COUNT_WIDTH-1:0] cfg_count_t;  // Per node update count

  // Sender FSM
  typedef enum logic [1:0] {
    IDLE,  // Line high, waiting for send_i
    SEND,  // Frame bits on the line
    GAP    // Trailing ones before the next frame
  } sender_state_t;

endpackage

`default_nettype wire

//--- include/cfg_chain_config.svh
`ifndef CFG_CHAIN_CONFIG_SVH
`define CFG_CHAIN_CONFIG_SVH

// Frame fields, sent LSB first: start bit, length, ID, data
`define CFG_ID_WIDTH    4
`define CFG_LEN_WIDTH   5
`define CFG_DATA_WIDTH  16   // Largest node register
`define CFG_FRAME_WIDTH (1 + `CFG_LEN_WIDTH + `CFG_ID_WIDTH + `CFG_DATA_WIDTH)

`define CFG_COUNT_WIDTH 8    // Update counter, wraps

// Broadcast reset frame ID, no node may use it
`define CFG_RESET_ID    ({`CFG_ID_WIDTH{1'b1}})

// Node IDs
`define CFG_NODE0_ID    1
`define CFG_NODE1_ID    2
`define CFG_NODE2_ID    5

// Register widths, must match the length field of a frame
`define CFG_NODE0_BITS  8
`define CFG_NODE1_BITS  16
`define CFG_NODE2_BITS  4

// Register values after reset or a reset frame
`define CFG_NODE0_DEFAULT 8'ha5
`define CFG_NODE1_DEFAULT 16'h1234
`define CFG_NODE2_DEFAULT 4'h9

`endif
